/* Makefile */
TOP := um245BridgeTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

/* hw/busSampler.sv */
module busSampler import busTypesPkg::*; (
    input  logic    _RD,
    input  logic    rstN,
    input  logic    rdN,
    input  logic    wr,
    output busEvent events
);

    logic [1:0] rdSync;  // [0] may go metastable
    logic [1:0] wrSync;
    logic       rdLast;  // previous synchronized level
    logic       wrLast;

    // two-flop synchronizers, parked at the idle level
    always_ff @(posedge _RD or negedge rstN) begin
        if (!rstN) begin
            rdSync <= 2'b11;
            wrSync <= 2'b11;
        end else begin
            rdSync <= {rdSync[0], rdN};
            wrSync <= {wrSync[0], wr};
        end
    end

    // Edge register. A pin edge first seen at clock edge n shows up as an
    // event pulse launched at edge n+2, i.e. on the third sampling edge.
    always_ff @(posedge _RD or negedge rstN) begin
        if (!rstN) begin
            rdLast <= 1'b1;
            wrLast <= 1'b1;
            events <= '0;
        end else begin
            rdLast         <= rdSync[1];
            wrLast         <= wrSync[1];
            events.rdStart <= rdLast & ~rdSync[1];  // falling
            events.rdEnd   <= ~rdLast & rdSync[1];  // rising
            events.wrStart <= wrLast & ~wrSync[1];
            events.wrEnd   <= ~wrLast & wrSync[1];
        end
    end

endmodule

/* hw/busTypesPkg.sv */
package busTypesPkg;

    // one-cycle pulses decoded from the synchronized bus strobes
    typedef struct packed {
        logic rdStart;  // rdN fell
        logic rdEnd;    // rdN rose
        logic wrStart;  // wr fell
        logic wrEnd;    // wr rose
    } busEvent;

    // One machine per direction walks through these states.
    // rxfN is active in flagReady and flagBusy, txeN only in flagReady.
    typedef enum logic [1:0] {
        flagIdle    = 2'd0,  // no data or no space
        flagReady   = 2'd1,  // flag driven low
        flagBusy    = 2'd2,  // strobe held low by processor
        flagRecover = 2'd3   // inactivity count running
    } flagState;

endpackage

/* hw/byteRing.sv */
module byteRing import hostTypesPkg::*; #(
    parameter int depth = 16
) (
    input  logic       _RD,
    input  logic       rstN,
    input  hostByte    push,
    input  logic       pop,
    output logic [7:0] head,
    output ringStatus  status
);

    localparam int idxW = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [idxW-1:0] lastIdx = idxW'(depth - 1);

    logic [7:0]      mem [depth];
    logic [idxW-1:0] rdIdx;
    logic [idxW-1:0] wrIdx;
    logic [15:0]     count;
    logic            doPush;
    logic            doPop;

    assign doPush = push.strobe && !status.full;  // dropped when full
    assign doPop  = pop && !status.empty;         // ignored when empty

    always_ff @(posedge _RD) begin
        if (doPush) begin
            mem[wrIdx] <= push.data;
        end
    end

    always_ff @(posedge _RD or negedge rstN) begin
        if (!rstN) begin
            rdIdx <= '0;
            wrIdx <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrIdx <= (wrIdx == lastIdx) ? '0 : wrIdx + idxW'(1);  // wrap, any depth
            end
            if (doPop) begin
                rdIdx <= (rdIdx == lastIdx) ? '0 : rdIdx + idxW'(1);
            end
            case ({doPush, doPop})
                2'b10: count <= count + 16'd1;
                2'b01: count <= count - 16'd1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    assign head = mem[rdIdx];  // oldest byte, valid when not empty

    assign status = '{
        empty: (count == 16'd0),
        full:  (count == 16'(depth)),
        count: count
    };

    countInRange: assert property (@(posedge _RD) disable iff (!rstN)
        count <= 16'(depth));

endmodule

/* hw/flagSequencer.sv */
module flagSequencer import busTypesPkg::*, hostTypesPkg::*; #(
    parameter int recoveryCycles = 3
) (
    input  logic       _RD,
    input  logic       rstN,
    input  busEvent    events,
    input  logic [7:0] dataIn,
    input  logic [7:0] rxHead,
    input  ringStatus  rxStatus,
    input  ringStatus  txStatus,
    output logic       rxPop,
    output hostByte    txPush,
    output logic [7:0] dataOut,
    output logic       dataOe,
    output logic       rxfN,
    output logic       txeN,
    output logic       protocolErr
);

    localparam int cntW = (recoveryCycles > 1) ? $clog2(recoveryCycles) : 1;
    localparam logic [cntW-1:0] cntLoad = cntW'(recoveryCycles - 1);

    flagState        rdState;
    flagState        rdNext;
    flagState        wrState;
    flagState        wrNext;
    logic [cntW-1:0] rdCnt;  // recovery cycles left
    logic [cntW-1:0] wrCnt;
    logic            rdAccept;
    logic            rdRelease;
    logic            wrAccept;

    assign rdAccept  = events.rdStart && (rdState == flagReady);
    assign rdRelease = events.rdEnd && (rdState == flagBusy);
    assign wrAccept  = events.wrStart && (wrState == flagReady);

    assign rxPop  = rdRelease;  // pop at end of read
    assign txPush = '{data: dataIn, strobe: wrAccept};

    always_comb begin
        rdNext = rdState;
        case (rdState)
            flagIdle: begin
                if (!rxStatus.empty) begin
                    rdNext = flagReady;
                end
            end
            flagReady: begin
                if (rdAccept) begin
                    rdNext = flagBusy;
                end
            end
            flagBusy: begin
                if (rdRelease) begin
                    rdNext = flagRecover;
                end
            end
            default: begin  // flagRecover, ring status already reflects the pop
                if (rdCnt == '0) begin
                    rdNext = rxStatus.empty ? flagIdle : flagReady;
                end
            end
        endcase
    end

    always_comb begin
        wrNext = wrState;
        case (wrState)
            flagIdle: begin
                if (!txStatus.full) begin
                    wrNext = flagReady;
                end
            end
            flagReady: begin
                if (wrAccept) begin
                    wrNext = flagBusy;
                end
            end
            flagBusy: begin
                if (events.wrEnd) begin
                    wrNext = flagRecover;
                end
            end
            default: begin
                if (wrCnt == '0) begin
                    wrNext = txStatus.full ? flagIdle : flagReady;  // back-pressure
                end
            end
        endcase
    end

    // read direction
    always_ff @(posedge _RD or negedge rstN) begin
        if (!rstN) begin
            rdState <= flagIdle;
            rdCnt   <= '0;
            rxfN    <= 1'b1;
            dataOe  <= 1'b0;
        end else begin
            rdState <= rdNext;
            rxfN    <= !(rdNext == flagReady || rdNext == flagBusy);
            if (rdRelease) begin
                rdCnt <= cntLoad;
            end else if (rdState == flagRecover && rdCnt != '0) begin
                rdCnt <= rdCnt - cntW'(1);
            end
            if (rdAccept) begin
                dataOe <= 1'b1;
            end else if (rdRelease) begin
                dataOe <= 1'b0;
            end
        end
    end

    always_ff @(posedge _RD) begin
        if (rdAccept) begin
            dataOut <= rxHead;  // held for the whole strobe
        end
    end

    // write direction, starts in recovery so txeN stays off after reset
    always_ff @(posedge _RD or negedge rstN) begin
        if (!rstN) begin
            wrState <= flagRecover;
            wrCnt   <= cntLoad;
            txeN    <= 1'b1;
        end else begin
            wrState <= wrNext;
            txeN    <= (wrNext != flagReady);
            if (events.wrEnd && wrState == flagBusy) begin
                wrCnt <= cntLoad;
            end else if (wrState == flagRecover && wrCnt != '0) begin
                wrCnt <= wrCnt - cntW'(1);
            end
        end
    end

    // sticky until reset
    always_ff @(posedge _RD or negedge rstN) begin
        if (!rstN) begin
            protocolErr <= 1'b0;
        end else if ((events.rdStart && rxfN) || (events.wrStart && txeN)) begin
            protocolErr <= 1'b1;
        end
    end

    oeNotIdle: assert property (@(posedge _RD) disable iff (!rstN)
        dataOe |-> rdState != flagIdle);

    // rxfN must stay off for the full inactivity period after a read
    rxfRecovery: assert property (@(posedge _RD) disable iff (!rstN)
        rxPop |=> rxfN [*recoveryCycles]);

endmodule

/* hw/hostTypesPkg.sv */
package hostTypesPkg;

    // Byte stream entry. The same shape is used for host pushes into the
    // receive ring and for bus writes into the transmit ring.
    typedef struct packed {
        logic [7:0] data;
        logic       strobe;  // one cycle per byte
    } hostByte;

    // ring occupancy as seen from outside
    typedef struct packed {
        logic        empty;
        logic        full;
        logic [15:0] count;  // wide enough for either ring
    } ringStatus;

endpackage

/* hw/um245Bridge.sv */
module um245Bridge import busTypesPkg::*, hostTypesPkg::*; #(
    parameter int rxDepth        = 16,
    parameter int txDepth        = 8,
    parameter int recoveryCycles = 3
) (
    input  logic       _RD,
    input  logic       rstN,
    input  hostByte    rxPush,
    input  logic       txTake,
    input  logic       rdN,
    input  logic       wr,
    input  logic [7:0] dataIn,
    output logic       rxFull,
    output logic       txValid,
    output logic [7:0] txByte,
    output logic [7:0] dataOut,
    output logic       dataOe,
    output logic       rxfN,
    output logic       txeN,
    output logic       protocolErr
);

    busEvent    events;
    ringStatus  rxStatus;
    ringStatus  txStatus;
    logic [7:0] rxHead;
    logic       rxPop;
    hostByte    txPush;  // bus writes toward host

    busSampler sampler (
        ._RD    (_RD),
        .rstN   (rstN),
        .rdN    (rdN),
        .wr     (wr),
        .events (events)
    );

    // host to processor
    byteRing #(
        .depth (rxDepth)
    ) rxRing (
        ._RD    (_RD),
        .rstN   (rstN),
        .push   (rxPush),
        .pop    (rxPop),
        .head   (rxHead),
        .status (rxStatus)
    );

    // processor to host, popped directly by txTake
    byteRing #(
        .depth (txDepth)
    ) txRing (
        ._RD    (_RD),
        .rstN   (rstN),
        .push   (txPush),
        .pop    (txTake),
        .head   (txByte),
        .status (txStatus)
    );

    flagSequencer #(
        .recoveryCycles (recoveryCycles)
    ) sequencer (
        ._RD         (_RD),
        .rstN        (rstN),
        .events      (events),
        .dataIn      (dataIn),
        .rxHead      (rxHead),
        .rxStatus    (rxStatus),
        .txStatus    (txStatus),
        .rxPop       (rxPop),
        .txPush      (txPush),
        .dataOut     (dataOut),
        .dataOe      (dataOe),
        .rxfN        (rxfN),
        .txeN        (txeN),
        .protocolErr (protocolErr)
    );

    assign rxFull  = rxStatus.full;
    assign txValid = !txStatus.empty;

endmodule

/* sim.f */
hw/busTypesPkg.sv
hw/hostTypesPkg.sv
hw/busSampler.sv
hw/byteRing.sv
hw/flagSequencer.sv
hw/um245Bridge.sv
sim/um245BridgeTb.sv

/* sim/um245BridgeTb.sv */
module um245BridgeTb import hostTypesPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int rxDepth        = 16;
    localparam int txDepth        = 8;
    localparam int recoveryCycles = 3;
    localparam int syncStages     = 3;  // first sampling edge to event at the sequencer

    localparam int rxRounds      = 6;   // up to 4 bytes each
    localparam int overflowExtra = 4;   // pushes past full
    localparam int txSteps       = 16;
    localparam int bpWindow      = 20;  // cycles txeN is watched while full
    localparam int errWindow     = 10;
    localparam int opCycles      = 24;  // worst bus op incl. sync and recovery
    localparam int timeoutLimit  = opCycles * (rxRounds * 8 + rxDepth + overflowExtra + rxDepth
                                   + txSteps + 3 * txDepth + 2 + 12) + bpWindow + errWindow + 200;

    logic       _RD;
    logic       rstN;
    hostByte    rxPush;
    logic       txTake;
    logic       rdN;
    logic       wr;
    logic [7:0] dataIn;
    logic       rxFull;
    logic       txValid;
    logic [7:0] txByte;
    logic [7:0] dataOut;
    logic       dataOe;
    logic       rxfN;
    logic       txeN;
    logic       protocolErr;

    logic [7:0]  rxModel[$];  // mirrors receive ring
    logic [7:0]  txModel[$];  // mirrors transmit ring
    logic [31:0] lfsrState = 32'h123f_d8cb;
    int          cycles = 0;
    int          errors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    um245Bridge um245Bridge_inst (
        ._RD         (_RD),
        .rstN        (rstN),
        .rxPush      (rxPush),
        .txTake      (txTake),
        .rdN         (rdN),
        .wr          (wr),
        .dataIn      (dataIn),
        .rxFull      (rxFull),
        .txValid     (txValid),
        .txByte      (txByte),
        .dataOut     (dataOut),
        .dataOe      (dataOe),
        .rxfN        (rxfN),
        .txeN        (txeN),
        .protocolErr (protocolErr)
    );

    always #2 _RD = ~_RD;

    always @(posedge _RD) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutLimit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    task automatic reportMismatch(input string signal, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("Mismatch %s expected %0h actual %0h at cycle %0d",
                 signal, expected, actual, cycles);
        errors++;
    endtask

    task automatic reportFailure(input string what);
        $display("Error at cycle %0d: %s", cycles, what);
        errors++;
    endtask

    task automatic reportTest(input string name, input int testErrors);
        if (testErrors == 0) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, testErrors);
            testsFailed++;
        end
        testsRun++;
    endtask

    task automatic applyReset();
        @(posedge _RD);
        rstN   <= 1'b0;
        rdN    <= 1'b1;
        wr     <= 1'b1;
        txTake <= 1'b0;
        rxPush <= '0;
        repeat (2) @(posedge _RD);
        rstN <= 1'b1;
        rxModel.delete();
        txModel.delete();
    endtask

    // flag must read high on minHigh consecutive cycles
    task automatic checkRecovery(input bit isTx, input int minHigh);
        int highRun;
        highRun = 0;
        @(negedge _RD);
        while ((isTx ? txeN : rxfN) == 1'b0) @(negedge _RD);
        while (highRun < minHigh && (isTx ? txeN : rxfN) == 1'b1) begin
            highRun++;
            @(negedge _RD);
        end
        assert (highRun == minHigh) else
            reportFailure($sformatf("%s returned low after only %0d of %0d high cycles",
                                    isTx ? "txeN" : "rxfN", highRun, minHigh));
    endtask

    task automatic hostPush(input logic [7:0] value);
        @(posedge _RD);
        rxPush <= '{data: value, strobe: 1'b1};
        @(posedge _RD);
        rxPush <= '{data: 8'h00, strobe: 1'b0};
        if (rxModel.size() < rxDepth) begin
            rxModel.push_back(value);  // dropped when full
        end
    endtask

    task automatic readExpect();
        logic [7:0] got;
        logic [7:0] expected;
        @(negedge _RD);
        while (rxfN) @(negedge _RD);
        @(posedge _RD);
        rdN <= 1'b0;
        @(negedge _RD);
        while (!dataOe) @(negedge _RD);
        got = dataOut;
        @(posedge _RD);
        rdN <= 1'b1;
        expected = rxModel.pop_front();
        assert (got === expected) else reportMismatch("dataOut", 32'(expected), 32'(got));
        checkRecovery(1'b0, recoveryCycles);  // rxfN rises when rdEnd is seen
    endtask

    task automatic busWrite(input logic [7:0] value);
        @(negedge _RD);
        while (txeN) @(negedge _RD);
        @(posedge _RD);
        wr     <= 1'b0;
        dataIn <= value;  // held until wr rises
        @(negedge _RD);
        while (!txeN) @(negedge _RD);  // accepted
        @(posedge _RD);
        wr <= 1'b1;
        txModel.push_back(value);
        checkRecovery(1'b1, 1 + syncStages + recoveryCycles);  // wr rise, wrEnd, recovery
    endtask

    task automatic hostTake();
        logic [7:0] expected;
        @(negedge _RD);
        assert (txValid === (txModel.size() != 0)) else
            reportMismatch("txValid", 32'(txModel.size() != 0), 32'(txValid));
        if (txModel.size() != 0) begin
            expected = txModel.pop_front();
            assert (txByte === expected) else
                reportMismatch("txByte", 32'(expected), 32'(txByte));
        end
        @(posedge _RD);
        txTake <= 1'b1;
        @(posedge _RD);
        txTake <= 1'b0;
    endtask

    task automatic testReceiveOrder();
        int startErrors;
        int burst;
        int gap;
        startErrors = errors;
        for (int round = 0; round < rxRounds; round++) begin
            burst = 1 + int'(randBits(2));
            gap   = int'(randBits(2));
            repeat (burst) hostPush(8'(randBits(8)));
            repeat (gap) @(posedge _RD);
            while (rxModel.size() != 0) readExpect();
        end
        reportTest("receive order", errors - startErrors);
    endtask

    task automatic testReceiveOverflow();
        int startErrors;
        startErrors = errors;
        for (int i = 0; i < rxDepth + overflowExtra; i++) begin
            hostPush(8'(randBits(8)));
            @(negedge _RD);
            assert (rxFull === (rxModel.size() == rxDepth)) else
                reportMismatch("rxFull", 32'(rxModel.size() == rxDepth), 32'(rxFull));
        end
        while (rxModel.size() != 0) readExpect();
        @(negedge _RD);
        assert (rxfN === 1'b1) else reportFailure("rxfN low after the receive ring drained");
        reportTest("receive overflow", errors - startErrors);
    endtask

    task automatic testTransmitPath();
        int   startErrors;
        logic doWrite;
        startErrors = errors;
        for (int step = 0; step < txSteps; step++) begin
            if (txModel.size() == 0) begin
                doWrite = 1'b1;
            end else if (txModel.size() == txDepth) begin
                doWrite = 1'b0;
            end else begin
                doWrite = (randBits(1) == 32'd1);  // write or take
            end
            if (doWrite) begin
                busWrite(8'(randBits(8)));
            end else begin
                hostTake();
            end
        end
        reportTest("transmit path", errors - startErrors);
    endtask

    task automatic testBackPressure();
        int startErrors;
        int watched;
        startErrors = errors;
        watched = 0;
        while (txModel.size() != 0) hostTake();
        repeat (txDepth) busWrite(8'(randBits(8)));
        while (watched < bpWindow) begin
            assert (txeN === 1'b1) else reportFailure("txeN fell while the transmit ring was full");
            watched++;
            @(negedge _RD);
        end
        hostTake();
        busWrite(8'(randBits(8)));  // needs the freed slot
        while (txModel.size() != 0) hostTake();
        @(negedge _RD);
        assert (txValid === 1'b0) else reportMismatch("txValid", 32'd0, 32'(txValid));
        reportTest("transmit back-pressure", errors - startErrors);
    endtask

    task automatic testRecovery();
        int startErrors;
        startErrors = errors;
        repeat (3) hostPush(8'(randBits(8)));
        repeat (3) readExpect();
        repeat (3) busWrite(8'(randBits(8)));
        repeat (3) hostTake();
        reportTest("recovery", errors - startErrors);
    endtask

    task automatic testProtocolError();
        int startErrors;
        int waited;
        startErrors = errors;
        waited = 0;
        @(negedge _RD);
        assert (rxfN === 1'b1) else reportMismatch("rxfN", 32'd1, 32'(rxfN));
        @(posedge _RD);
        rdN <= 1'b0;  // strobe with no data ready
        repeat (2) @(posedge _RD);
        rdN <= 1'b1;
        @(negedge _RD);
        while (!protocolErr && waited < errWindow) begin
            waited++;
            @(negedge _RD);
        end
        assert (protocolErr === 1'b1) else
            reportFailure("protocolErr did not rise after a read strobe with rxfN high");
        repeat (4) @(negedge _RD);  // let rdEnd pass
        assert (dataOe === 1'b0) else reportMismatch("dataOe", 32'd0, 32'(dataOe));
        assert (rxfN === 1'b1) else reportMismatch("rxfN", 32'd1, 32'(rxfN));
        assert (txValid === (txModel.size() != 0)) else
            reportMismatch("txValid", 32'(txModel.size() != 0), 32'(txValid));
        // receive ring must still behave as an empty ring
        hostPush(8'(randBits(8)));
        readExpect();
        applyReset();
        @(negedge _RD);
        assert (protocolErr === 1'b0) else
            reportMismatch("protocolErr", 32'd0, 32'(protocolErr));
        assert (txeN === 1'b1) else reportMismatch("txeN", 32'd1, 32'(txeN));
        reportTest("protocol error", errors - startErrors);
    endtask

    initial begin
        _RD    = 1'b0;
        rstN   = 1'b0;
        rxPush = '0;
        txTake = 1'b0;
        rdN    = 1'b1;  // strobes idle high
        wr     = 1'b1;
        dataIn = 8'h00;
        repeat (2) @(posedge _RD);
        rstN <= 1'b1;
        testReceiveOrder();
        testReceiveOverflow();
        testTransmitPath();
        testBackPressure();
        testRecovery();
        testProtocolError();
        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
